// ==== cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

////////////////////////////////////////////////////////////////////////
// datapath sizes
////////////////////////////////////////////////////////////////////////

`define DATA_W   16      // data and instruction word
`define REG_N    16      // register count
`define REG_W    4       // register index bits
`define LINK_REG 4'd15   // JAL target, JRA source

////////////////////////////////////////////////////////////////////////
// instruction fields
////////////////////////////////////////////////////////////////////////

`define OP_W     4       // major opcode
`define FUNC_W   4       // opExt function code
`define IMM_W    8       // I-type immediate
`define SHAMT_W  5       // signed shift amount

`endif

// ==== cpuPkg.sv ====
`default_nettype none

`include "cpu_params.svh"

package cpuPkg;

  // alu operations, reference encodings
  typedef enum logic [2:0] {
    opAdd  = 3'b000,
    opSub  = 3'b001,
    opOr   = 3'b010,
    opAnd  = 3'b011,
    opXor  = 3'b100,
    opNot  = 3'b101,
    opMult = 3'b110,
    opCmp  = 3'b111
  } aluOp;

  // controller outputs, one bundle
  typedef struct packed {
    logic branch;      // Bcond
    logic jump;        // J / JAL
    logic jumpRA;      // JRA
    logic CFWrite;     // load C and F
    logic LZNWrite;    // load L, Z and N
    logic wbPSR;       // write condition result
    logic RtSrcReg;    // store data from rdest
    logic wbSrc;       // 1 exec result, 0 memory
    logic memSrc;      // 1 alu, 0 shifter
    logic shiftSrc;    // 1 register amount, 0 immediate
    logic aluSrcb;     // 1 register b, 0 imm8
    logic regWriteEn;
    logic raWrite;     // write to link register
    logic shiftType;   // 1 arithmetic
    logic memWrite;
    logic pcEn;
    aluOp aluop;
  } ctrlSignals;

  typedef struct packed {
    logic C;  // unsigned carry
    logic F;  // signed overflow
    logic L;  // lower, unsigned
    logic Z;  // equal
    logic N;  // lower, signed
  } psrFlags;

  typedef struct packed {
    logic [`OP_W-1:0]   opCode;
    logic [`REG_W-1:0]  rdest;
    logic [`FUNC_W-1:0] opExt;
    logic [`REG_W-1:0]  rsrc;
  } rFields;

  typedef struct packed {
    logic [`OP_W-1:0]  opCode;
    logic [`REG_W-1:0] rdest;
    logic [`IMM_W-1:0] imm;
  } iFields;

  // same word, meaning depends on opcode
  typedef union packed {
    rFields r;
    iFields i;
  } instrWord;

  // major opcodes
  localparam logic [`OP_W-1:0] RTYPE  = 4'b0000;
  localparam logic [`OP_W-1:0] ANDI   = 4'b0001;
  localparam logic [`OP_W-1:0] ORI    = 4'b0010;
  localparam logic [`OP_W-1:0] XORI   = 4'b0011;
  localparam logic [`OP_W-1:0] SCOND  = 4'b0100;
  localparam logic [`OP_W-1:0] ADDI   = 4'b0101;
  localparam logic [`OP_W-1:0] JRA    = 4'b0110;
  localparam logic [`OP_W-1:0] LOAD   = 4'b0111;
  localparam logic [`OP_W-1:0] RTYPE2 = 4'b1000;
  localparam logic [`OP_W-1:0] SUBI   = 4'b1001;
  localparam logic [`OP_W-1:0] STR    = 4'b1010;
  localparam logic [`OP_W-1:0] CMPI   = 4'b1011;
  localparam logic [`OP_W-1:0] BCOND  = 4'b1100;
  localparam logic [`OP_W-1:0] J      = 4'b1101;
  localparam logic [`OP_W-1:0] MULTI  = 4'b1110;
  localparam logic [`OP_W-1:0] JAL    = 4'b1111;

  // RTYPE function codes
  localparam logic [`FUNC_W-1:0] AND  = 4'b0001;
  localparam logic [`FUNC_W-1:0] OR   = 4'b0010;
  localparam logic [`FUNC_W-1:0] XOR  = 4'b0011;
  localparam logic [`FUNC_W-1:0] NOT  = 4'b0100;
  localparam logic [`FUNC_W-1:0] ADD  = 4'b0101;
  localparam logic [`FUNC_W-1:0] ADDU = 4'b0110;
  localparam logic [`FUNC_W-1:0] SUB  = 4'b1001;
  localparam logic [`FUNC_W-1:0] CMP  = 4'b1011;
  localparam logic [`FUNC_W-1:0] MULT = 4'b1110;

  // RTYPE2 function codes, bit 0 of the I forms is the amount msb
  localparam logic [`FUNC_W-1:0] LSHI = 4'b0000;
  localparam logic [`FUNC_W-1:0] ASHI = 4'b0011;
  localparam logic [`FUNC_W-1:0] LSH  = 4'b0100;
  localparam logic [`FUNC_W-1:0] ASH  = 4'b0110;

endpackage

`default_nettype wire

// ==== logicController.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cpu_params.svh"

module logicController (
  input  logic               clk,
  input  logic               reset,
  input  logic [`OP_W-1:0]   opCode,
  input  logic [`FUNC_W-1:0] functionCode,
  output cpuPkg::ctrlSignals ctrl
);
  import cpuPkg::*;

  localparam logic EX  = 1'b0;
  localparam logic MEM = 1'b1;

  logic state;      // EX or MEM
  logic nextState;
  logic isMem;      // load or store in decode

  assign isMem = (opCode == LOAD) || (opCode == STR);

  ////////////////////////////////////////////////////////////////////
  // state register
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= EX;
    else
      state <= nextState;
  end

  assign nextState = (state == EX && isMem) ? MEM : EX;  // MEM lasts one cycle

  ////////////////////////////////////////////////////////////////////
  // decoder
  ////////////////////////////////////////////////////////////////////

  always_comb
  begin
    ctrl = '0;
    ctrl.aluop = opAdd;
    ctrl.pcEn = !(state == EX && isMem);  // stall pc for the MEM cycle
    case (opCode)
      ADDI, SUBI, CMPI, MULTI, ANDI, ORI, XORI:
      begin
        ctrl.wbSrc = 1'b1;                 // alu result to rf
        ctrl.memSrc = 1'b1;
        ctrl.regWriteEn = (opCode != CMPI); // compare only sets flags
        ctrl.CFWrite = (opCode == ADDI) || (opCode == SUBI);
        ctrl.LZNWrite = (opCode == CMPI);
        case (opCode)
          SUBI:    ctrl.aluop = opSub;
          CMPI:    ctrl.aluop = opCmp;
          MULTI:   ctrl.aluop = opMult;
          ANDI:    ctrl.aluop = opAnd;
          ORI:     ctrl.aluop = opOr;
          XORI:    ctrl.aluop = opXor;
          default: ctrl.aluop = opAdd;
        endcase
      end
      BCOND: ctrl.branch = 1'b1;         // cond in rdest
      J:     ctrl.jump = 1'b1;
      JAL:
      begin
        ctrl.jump = 1'b1;
        ctrl.raWrite = 1'b1;               // pc+1 into r15
        ctrl.regWriteEn = 1'b1;
      end
      JRA:   ctrl.jumpRA = 1'b1;
      RTYPE:
      begin
        ctrl.wbSrc = 1'b1;
        ctrl.memSrc = 1'b1;
        ctrl.aluSrcb = 1'b1;               // second operand from rsrc
        ctrl.regWriteEn = 1'b1;
        case (functionCode)
          ADD:  ctrl.CFWrite = 1'b1;
          ADDU: ctrl.aluop = opAdd;        // no flag update
          SUB:
          begin
            ctrl.CFWrite = 1'b1;
            ctrl.aluop = opSub;
          end
          MULT: ctrl.aluop = opMult;
          CMP:
          begin
            ctrl.LZNWrite = 1'b1;
            ctrl.regWriteEn = 1'b0;        // flags only
            ctrl.aluop = opCmp;
          end
          AND:  ctrl.aluop = opAnd;
          OR:   ctrl.aluop = opOr;
          XOR:  ctrl.aluop = opXor;
          NOT:  ctrl.aluop = opNot;        // inverts operand b
          default: ctrl.CFWrite = 1'b1;    // treat as ADD
        endcase
      end
      RTYPE2:
      begin
        ctrl.wbSrc = 1'b1;                 // shifter via memSrc=0
        ctrl.regWriteEn = 1'b1;
        case (functionCode[`FUNC_W-1:1])   // lsb of the I forms is amount msb
          LSHI[`FUNC_W-1:1]: ctrl.shiftSrc = 1'b0;
          ASHI[`FUNC_W-1:1]: ctrl.shiftType = 1'b1;
          ASH[`FUNC_W-1:1]:
          begin
            ctrl.shiftSrc = 1'b1;
            ctrl.shiftType = 1'b1;
          end
          LSH[`FUNC_W-1:1]: ctrl.shiftSrc = 1'b1;
          default: ctrl.shiftSrc = 1'b1;   // register logical shift
        endcase
      end
      LOAD:  ctrl.regWriteEn = (state == MEM);  // dataIn via wbSrc=0
      STR:
      begin
        ctrl.RtSrcReg = 1'b1;              // rdest is the store data
        ctrl.memWrite = (state == MEM);    // one strobe per store
      end
      SCOND:
      begin
        ctrl.wbPSR = 1'b1;                 // 1/0 from condition
        ctrl.regWriteEn = 1'b1;
      end
      default:
      begin
        ctrl.wbSrc = 1'b1;                 // unknown op, nothing written
        ctrl.memSrc = 1'b1;
      end
    endcase
  end

  // MEM cycle only ever sees a load or store word
  memOpInMem: assert property (@(posedge clk) disable iff (reset)
    state == MEM |-> isMem);

  // pc stall keeps the same instruction into MEM
  memSameInstr: assert property (@(posedge clk) disable iff (reset)
    (state == EX && isMem) |=> $stable(opCode) && $stable(functionCode));

endmodule

`default_nettype wire

// ==== aluUnit.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cpu_params.svh"

module aluUnit (
  input  logic [`DATA_W-1:0] a,
  input  logic [`DATA_W-1:0] b,
  input  cpuPkg::aluOp       op,
  output logic [`DATA_W-1:0] result,
  output cpuPkg::psrFlags    flagsNext
);
  import cpuPkg::*;

  logic [`DATA_W:0] sum;     // extra bit is the carry
  logic [`DATA_W:0] diff;    // extra bit is the borrow
  logic             addOvf;
  logic             subOvf;

  assign sum  = {1'b0, a} + {1'b0, b};
  assign diff = {1'b0, a} - {1'b0, b};

  // same-sign inputs, result sign flipped
  assign addOvf = (a[`DATA_W-1] == b[`DATA_W-1]) &&
                  (sum[`DATA_W-1] != a[`DATA_W-1]);
  // opposite-sign inputs, result takes sign of b
  assign subOvf = (a[`DATA_W-1] != b[`DATA_W-1]) &&
                  (diff[`DATA_W-1] != a[`DATA_W-1]);

  ////////////////////////////////////////////////////////////////////
  // result
  ////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (op)
      opAdd:   result = sum[`DATA_W-1:0];
      opSub:   result = diff[`DATA_W-1:0];
      opOr:    result = a | b;
      opAnd:   result = a & b;
      opXor:   result = a ^ b;
      opNot:   result = ~b;                 // unary on operand b
      opMult:  result = a * b;              // low half of product
      opCmp:   result = diff[`DATA_W-1:0];  // not written back
      default: result = sum[`DATA_W-1:0];
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // flags, the core picks which group to load
  ////////////////////////////////////////////////////////////////////

  always_comb
  begin
    if (op == opSub)
    begin
      flagsNext.C = diff[`DATA_W];  // borrow out
      flagsNext.F = subOvf;
    end
    else
    begin
      flagsNext.C = sum[`DATA_W];
      flagsNext.F = addOvf;
    end
    flagsNext.Z = (a == b);
    flagsNext.L = (a < b);                    // unsigned compare
    flagsNext.N = ($signed(a) < $signed(b));  // signed compare
  end

endmodule

`default_nettype wire

// ==== shiftUnit.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cpu_params.svh"

module shiftUnit (
  input  logic [`DATA_W-1:0]  value,
  input  logic [`SHAMT_W-1:0] amount,   // two's complement, neg is right
  input  logic                arith,
  output logic [`DATA_W-1:0]  shifted
);

  logic [`SHAMT_W-1:0] magnitude;  // |amount|, 16 fits as 5'b10000

  assign magnitude = amount[`SHAMT_W-1] ? -amount : amount;

  always_comb
  begin
    if (!amount[`SHAMT_W-1])
      shifted = value << magnitude;            // left, zero fill
    else if (arith)
      shifted = $signed(value) >>> magnitude;  // right, sign fill
    else
      shifted = value >> magnitude;            // right, zero fill
  end

endmodule

`default_nettype wire

// ==== registerFile.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cpu_params.svh"

module registerFile (
  input  logic               clk,
  input  logic               reset,
  input  logic [`REG_W-1:0]  readA,
  input  logic [`REG_W-1:0]  readB,
  input  logic [`REG_W-1:0]  writeAddr,
  input  logic               writeEn,
  input  logic [`DATA_W-1:0] writeData,
  output logic [`DATA_W-1:0] dataA,
  output logic [`DATA_W-1:0] dataB
);

  logic [`DATA_W-1:0] regs [`REG_N];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `REG_N; i++)
        regs[i] <= '0;                 // all registers cleared
    end
    else if (writeEn)
      regs[writeAddr] <= writeData;
  end

  // async read, new value visible after the edge
  assign dataA = regs[readA];
  assign dataB = regs[readB];

  // decode or datapath leaving X on a write
  writeDataKnown: assert property (@(posedge clk) disable iff (reset)
    writeEn |-> !$isunknown(writeData));

endmodule

`default_nettype wire

// ==== cpuCore.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cpu_params.svh"

module cpuCore (
  input  logic               clk,
  input  logic               reset,
  output logic [`DATA_W-1:0] instrAddr,
  input  logic [`DATA_W-1:0] instrData,
  output logic [`DATA_W-1:0] dataAddr,
  output logic [`DATA_W-1:0] dataOut,
  output logic               dataWrite,
  input  logic [`DATA_W-1:0] dataIn
);
  import cpuPkg::*;

  instrWord   instr;
  ctrlSignals ctrl;
  psrFlags    psr;
  psrFlags    flagsNext;

  logic [`DATA_W-1:0]  pc;
  logic [`DATA_W-1:0]  pcNext;
  logic [`DATA_W-1:0]  pcPlus1;
  logic [`DATA_W-1:0]  regA;         // rdest value
  logic [`DATA_W-1:0]  regB;         // rsrc value, r15 on JRA
  logic [`DATA_W-1:0]  immExt;
  logic [`DATA_W-1:0]  operandB;
  logic [`DATA_W-1:0]  aluResult;
  logic [`DATA_W-1:0]  shiftResult;
  logic [`DATA_W-1:0]  exResult;
  logic [`DATA_W-1:0]  writeData;
  logic [`SHAMT_W-1:0] shiftAmount;
  logic [`REG_W-1:0]   readBAddr;
  logic [`REG_W-1:0]   writeAddr;
  logic [`REG_W-1:0]   condCode;
  logic                condTrue;

  assign instr     = instrData;
  assign instrAddr = pc;
  assign pcPlus1   = pc + 1'b1;
  assign immExt    = {{(`DATA_W-`IMM_W){instr.i.imm[`IMM_W-1]}}, instr.i.imm};

  ////////////////////////////////////////////////////////////////////
  // control and datapath blocks
  ////////////////////////////////////////////////////////////////////

  logicController u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .opCode       (instr.r.opCode),
    .functionCode (instr.r.opExt),
    .ctrl         (ctrl)
  );

  assign readBAddr = ctrl.jumpRA ? `LINK_REG : instr.r.rsrc;   // JRA reads the link
  assign writeAddr = ctrl.raWrite ? `LINK_REG : instr.r.rdest;

  registerFile u_regs (
    .clk       (clk),
    .reset     (reset),
    .readA     (instr.r.rdest),
    .readB     (readBAddr),
    .writeAddr (writeAddr),
    .writeEn   (ctrl.regWriteEn),
    .writeData (writeData),
    .dataA     (regA),
    .dataB     (regB)
  );

  assign operandB = ctrl.aluSrcb ? regB : immExt;

  aluUnit u_alu (
    .a         (regA),
    .b         (operandB),
    .op        (ctrl.aluop),
    .result    (aluResult),
    .flagsNext (flagsNext)
  );

  // register amount or 5-bit immediate {opExt[0], rsrc}
  assign shiftAmount = ctrl.shiftSrc ? regB[`SHAMT_W-1:0] :
                                       {instr.r.opExt[0], instr.r.rsrc};

  shiftUnit u_shift (
    .value   (regA),
    .amount  (shiftAmount),
    .arith   (ctrl.shiftType),
    .shifted (shiftResult)
  );

  ////////////////////////////////////////////////////////////////////
  // conditions and psr
  ////////////////////////////////////////////////////////////////////

  assign condCode = ctrl.branch ? instr.i.rdest : instr.r.rsrc;  // Bcond vs Scond

  always_comb
  begin
    case (condCode)
      4'd0:    condTrue = psr.Z;     // EQ
      4'd1:    condTrue = !psr.Z;    // NE
      4'd2:    condTrue = psr.C;     // CS
      4'd3:    condTrue = !psr.C;    // CC
      4'd4:    condTrue = psr.L;     // HI
      4'd5:    condTrue = !psr.L;    // LS
      4'd6:    condTrue = psr.N;     // GT
      4'd7:    condTrue = !psr.N;    // LE
      4'd14:   condTrue = 1'b1;      // always
      default: condTrue = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      psr <= '0;
    else
    begin
      if (ctrl.CFWrite)
      begin
        psr.C <= flagsNext.C;
        psr.F <= flagsNext.F;
      end
      if (ctrl.LZNWrite)
      begin
        psr.L <= flagsNext.L;
        psr.Z <= flagsNext.Z;
        psr.N <= flagsNext.N;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // write back, memory and pc
  ////////////////////////////////////////////////////////////////////

  assign exResult = ctrl.memSrc ? aluResult : shiftResult;

  always_comb
  begin
    if (ctrl.wbPSR)
      writeData = {{(`DATA_W-1){1'b0}}, condTrue};  // Scond result
    else if (ctrl.raWrite)
      writeData = pcPlus1;                           // JAL link
    else if (ctrl.wbSrc)
      writeData = exResult;
    else
      writeData = dataIn;                            // load data
  end

  assign dataAddr  = regB;                                // address in rsrc
  assign dataOut   = ctrl.RtSrcReg ? regA : exResult;     // store data is rdest
  assign dataWrite = ctrl.memWrite;

  always_comb
  begin
    pcNext = pc;                             // held during the EX of a load/store
    if (ctrl.pcEn)
    begin
      if (ctrl.jump || ctrl.jumpRA)
        pcNext = regB;                       // rsrc or r15
      else if (ctrl.branch && condTrue)
        pcNext = pc + immExt;                // relative to the branch
      else
        pcNext = pcPlus1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      pc <= '0;
    else
      pc <= pcNext;
  end

  // each store is a single-cycle strobe
  singleStoreStrobe: assert property (@(posedge clk) disable iff (reset)
    dataWrite |=> !dataWrite);

endmodule

`default_nettype wire

// ==== tbCpu.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cpu_params.svh"

module tbCpu;
  import cpuPkg::*;

  localparam int          CYCLE_LIMIT = 3000;      // six programs, each far below 500 cycles
  localparam logic [15:0] STORE_BASE  = 16'h0040;  // address of ordinary result stores
  localparam logic [3:0]  R_ADDR      = 4'd13;     // holds STORE_BASE
  localparam logic [3:0]  R_HALT      = 4'd14;     // holds the halt address
  localparam logic [15:0] SHIFT_SRC   = 16'h8421;

  logic               clk;
  logic               reset;
  logic [`DATA_W-1:0] instrAddr;
  logic [`DATA_W-1:0] instrData;
  logic [`DATA_W-1:0] dataAddr;
  logic [`DATA_W-1:0] dataOut;
  logic               dataWrite;
  logic [`DATA_W-1:0] dataIn;

  logic [15:0] rom [0:1023];  // instruction ROM
  logic [15:0] ram [0:255];   // data RAM
  logic        visited [0:1023];
  logic [31:0] expQ [$];      // {addr, data} predicted stores
  logic [31:0] capQ [$];      // {addr, data} seen on the bus

  int          pcIdx;
  logic [15:0] haltAddr;
  logic [31:0] lcgState;
  int          valueErrors;
  int          protocolErrors;
  int          cycleCount;
  int          memHolds;      // memory instructions with a two-cycle fetch
  logic [15:0] holdAddr;
  int          holdCount;
  logic        holdValid;
  logic        prevWrite;
  logic [3:0]  holdOp;

  cpuCore u_dut (
    .clk       (clk),
    .reset     (reset),
    .instrAddr (instrAddr),
    .instrData (instrData),
    .dataAddr  (dataAddr),
    .dataOut   (dataOut),
    .dataWrite (dataWrite),
    .dataIn    (dataIn)
  );

  assign instrData = rom[instrAddr[9:0]];  // combinational ROM
  assign dataIn    = ram[dataAddr[7:0]];   // combinational RAM read

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // memory models and bus monitors
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (!reset && dataWrite)
    begin
      ram[dataAddr[7:0]] <= dataOut;
      capQ.push_back({dataAddr, dataOut});  // every strobe recorded
    end
  end

  always @(posedge clk)
  begin
    if (reset)
    begin
      holdValid = 1'b0;
      prevWrite = 1'b0;
    end
    else
    begin
      visited[instrAddr[9:0]] = 1'b1;
      if (dataWrite && prevWrite)
      begin
        protocolErrors++;
        $display("error at %0t: dataWrite stayed high for two cycles", $time);
      end
      prevWrite = dataWrite;
      if (holdValid && instrAddr == holdAddr)
        holdCount++;
      else
      begin
        if (holdValid)
        begin
          holdOp = rom[holdAddr[9:0]][15:12];
          if ((holdOp == LOAD || holdOp == STR) && holdCount != 2)
          begin
            protocolErrors++;
            $display("error at %0t: memory op at %h fetched for %0d cycles instead of 2",
                     $time, holdAddr, holdCount);
          end
          else if (holdOp != LOAD && holdOp != STR && holdCount != 1)
          begin
            protocolErrors++;
            $display("error at %0t: instruction at %h fetched for %0d cycles instead of 1",
                     $time, holdAddr, holdCount);
          end
          else if (holdOp == LOAD || holdOp == STR)
            memHolds++;
        end
        holdAddr  = instrAddr;
        holdCount = 1;
        holdValid = 1'b1;
      end
    end
  end

  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount >= CYCLE_LIMIT)
    begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("test failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // encoders and model functions
  //////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] rWord(input logic [3:0] op, input logic [3:0] rd,
                                        input logic [3:0] ext, input logic [3:0] rs);
    return {op, rd, ext, rs};
  endfunction

  function automatic logic [15:0] iWord(input logic [3:0] op, input logic [3:0] rd,
                                        input logic [7:0] imm);
    return {op, rd, imm};
  endfunction

  // amount msb rides in opExt bit 0
  function automatic logic [15:0] shiftWord(input logic [3:0] fc, input logic [3:0] rd,
                                            input logic [4:0] amt);
    return {RTYPE2, rd, fc[3:1], amt[4], amt[3:0]};
  endfunction

  function automatic logic [15:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState[31:16];  // upper half, better period
  endfunction

  function automatic logic [15:0] ramFill(input logic [7:0] addr);
    return {addr, ~addr} ^ 16'h3c96;
  endfunction

  // flags as left by CMP a,b
  function automatic logic condModel(input logic [3:0] code, input logic [15:0] a,
                                     input logic [15:0] b);
    logic z;
    logic l;
    logic n;
    z = (a == b);
    l = (a < b);
    n = ($signed(a) < $signed(b));
    case (code)
      4'd0:    return z;
      4'd1:    return !z;
      4'd4:    return l;
      4'd5:    return !l;
      4'd6:    return n;
      4'd7:    return !n;
      4'd14:   return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [15:0] shiftModel(input logic [15:0] v, input int amt,
                                             input logic arith);
    if (amt >= 0)
      return v << amt;
    else if (arith)
      return $signed(v) >>> (-amt);
    else
      return v >> (-amt);
  endfunction

  function automatic logic [3:0] pickCode(input logic [15:0] r);
    case (r % 6)
      0:       return 4'd0;
      1:       return 4'd1;
      2:       return 4'd4;
      3:       return 4'd5;
      4:       return 4'd6;
      default: return 4'd7;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // program building and running
  //////////////////////////////////////////////////////////////////////

  task automatic emitWord(input logic [15:0] w);
    rom[pcIdx] = w;
    pcIdx++;
  endtask

  // clear, high byte pre-corrected for the sign-extended low byte
  task automatic loadConst(input logic [3:0] r, input logic [15:0] v);
    logic [15:0] hiPart;
    hiPart = v - {{8{v[7]}}, v[7:0]};
    emitWord(iWord(ANDI, r, 8'h00));
    emitWord(iWord(ADDI, r, hiPart[15:8]));
    emitWord(shiftWord(LSHI, r, 5'd8));
    emitWord(iWord(ADDI, r, v[7:0]));
  endtask

  task automatic copyReg(input logic [3:0] dst, input logic [3:0] src);
    emitWord(iWord(ANDI, dst, 8'h00));
    emitWord(rWord(RTYPE, dst, OR, src));  // no flags touched
  endtask

  task automatic storeRaw(input logic [3:0] r);
    emitWord(rWord(STR, r, 4'd0, R_ADDR));
  endtask

  task automatic storeValue(input logic [3:0] r, input logic [15:0] expected);
    storeRaw(r);
    expQ.push_back({STORE_BASE, expected});
  endtask

  task automatic beginProgram();
    int i;
    @(posedge clk);
    reset <= 1'b1;
    @(posedge clk);  // reset now seen by the DUT
    for (i = 0; i < 1024; i++)
    begin
      rom[i] = 16'h0000;
      visited[i] = 1'b0;
    end
    pcIdx = 0;
    expQ.delete();
    capQ.delete();
    memHolds = 0;
    emitWord(iWord(ADDI, R_ADDR, STORE_BASE[7:0]));
  endtask

  // J to its own address
  task automatic endProgram();
    logic [15:0] target;
    target = pcIdx + 4;
    loadConst(R_HALT, target);
    haltAddr = pcIdx;
    emitWord(rWord(J, 4'd0, 4'd0, R_HALT));
  endtask

  task automatic reportValue(input string what, input logic [15:0] got,
                             input logic [15:0] expected);
    valueErrors++;
    $display("FAIL %0t: %s got %h expected %h", $time, what, got, expected);
  endtask

  task automatic runProgram(input string name);
    int i;
    @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    while (instrAddr !== haltAddr)  // halt loop is the done signal
      @(posedge clk);
    @(posedge clk);
    if (capQ.size() != expQ.size())
      reportValue({name, " store count"}, capQ.size(), expQ.size());
    for (i = 0; i < expQ.size() && i < capQ.size(); i++)
    begin
      if (capQ[i][31:16] !== expQ[i][31:16])
        reportValue($sformatf("%s store %0d dataAddr", name, i), capQ[i][31:16],
                    expQ[i][31:16]);
      if (capQ[i][15:0] !== expQ[i][15:0])
        reportValue($sformatf("%s store %0d dataOut", name, i), capQ[i][15:0],
                    expQ[i][15:0]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic aluCase(input logic [3:0] fc, input logic [15:0] expected);
    copyReg(4'd3, 4'd1);
    emitWord(rWord(RTYPE, 4'd3, fc, 4'd2));  // r3 = r3 op r2
    storeValue(4'd3, expected);
  endtask

  task automatic aluTest();
    logic [15:0] a;
    logic [15:0] b;
    beginProgram();
    a = nextRand();
    b = nextRand();
    loadConst(4'd1, a);
    loadConst(4'd2, b);
    aluCase(ADD, a + b);
    aluCase(SUB, a - b);
    aluCase(AND, a & b);
    aluCase(OR, a | b);
    aluCase(XOR, a ^ b);
    aluCase(NOT, ~b);   // operand b inverted
    aluCase(MULT, a * b);  // low half
    endProgram();
    runProgram("alu");
  endtask

  task automatic immShift(input logic [3:0] fc, input int amt, input logic arith);
    logic [4:0] amt5;
    amt5 = amt[4:0];
    copyReg(4'd5, 4'd4);
    emitWord(shiftWord(fc, 4'd5, amt5));
    storeValue(4'd5, shiftModel(SHIFT_SRC, amt, arith));
  endtask

  task automatic regShift(input logic [3:0] fc, input int amt, input logic arith);
    logic [15:0] amt16;
    amt16 = amt;
    loadConst(4'd6, amt16);
    copyReg(4'd5, 4'd4);
    emitWord(rWord(RTYPE2, 4'd5, fc, 4'd6));
    storeValue(4'd5, shiftModel(SHIFT_SRC, amt, arith));
  endtask

  task automatic shiftTest();
    beginProgram();
    emitWord(iWord(ADDI, 4'd1, 8'hF3));  // negative imm
    storeValue(4'd1, 16'hFFF3);
    emitWord(iWord(ADDI, 4'd1, 8'h35));
    storeValue(4'd1, 16'h0028);
    loadConst(4'd2, 16'h1000);
    emitWord(iWord(SUBI, 4'd2, 8'h80));  // minus -128
    storeValue(4'd2, 16'h1080);
    loadConst(4'd3, 16'h5A5A);
    emitWord(iWord(ORI, 4'd3, 8'h81));
    storeValue(4'd3, 16'hFFDB);
    loadConst(4'd4, SHIFT_SRC);
    immShift(LSHI, 3, 1'b0);
    immShift(LSHI, -4, 1'b0);
    immShift(ASHI, -4, 1'b1);   // sign fill
    immShift(ASHI, 2, 1'b1);
    regShift(LSH, 5, 1'b0);
    regShift(LSH, -3, 1'b0);
    regShift(ASH, -3, 1'b1);
    endProgram();
    runProgram("shift");
  endtask

  task automatic scondCheck(input logic [3:0] code, input logic [15:0] a,
                            input logic [15:0] b);
    emitWord(rWord(SCOND, 4'd3, 4'd0, code));
    storeValue(4'd3, {15'd0, condModel(code, a, b)});
  endtask

  task automatic cmpCase(input logic [15:0] a, input logic [15:0] b);
    loadConst(4'd1, a);
    loadConst(4'd2, b);
    emitWord(rWord(RTYPE, 4'd1, CMP, 4'd2));
    scondCheck(4'd0, a, b);
    scondCheck(4'd1, a, b);
    scondCheck(4'd4, a, b);
    scondCheck(4'd6, a, b);
    scondCheck(4'd7, a, b);
  endtask

  // C is carry out on add, borrow on subtract
  task automatic carryCase(input logic isSub, input logic [15:0] a, input logic [15:0] b);
    logic [16:0] sum;
    logic        carry;
    sum = {1'b0, a} + {1'b0, b};
    carry = isSub ? (a < b) : sum[16];
    loadConst(4'd3, a);
    loadConst(4'd4, b);
    emitWord(rWord(RTYPE, 4'd3, isSub ? SUB : ADD, 4'd4));
    emitWord(rWord(SCOND, 4'd5, 4'd0, 4'd2));  // CS
    storeValue(4'd5, {15'd0, carry});
  endtask

  task automatic condTest();
    beginProgram();
    cmpCase(16'h1234, 16'h1234);
    cmpCase(16'h0010, 16'h8000);  // unsigned lower, signed higher
    carryCase(1'b0, 16'hFFF0, 16'h0020);
    carryCase(1'b0, 16'h0100, 16'h0200);
    carryCase(1'b1, 16'h0005, 16'h0007);
    carryCase(1'b1, 16'h0009, 16'h0002);
    loadConst(4'd8, 16'h1111);
    loadConst(4'd9, 16'h2222);
    emitWord(rWord(RTYPE, 4'd1, CMP, 4'd1));  // Z set
    emitWord(iWord(BCOND, 4'd0, 8'd2));        // EQ taken, skips r8
    storeRaw(4'd8);
    storeValue(4'd9, 16'h2222);
    emitWord(iWord(BCOND, 4'd1, 8'd2));        // NE falls through
    storeValue(4'd8, 16'h1111);
    storeValue(4'd9, 16'h2222);
    endProgram();
    runProgram("cond");
  endtask

  task automatic memTest();
    beginProgram();
    loadConst(4'd2, 16'h0080);
    emitWord(rWord(LOAD, 4'd3, 4'd0, 4'd2));
    storeValue(4'd3, ramFill(8'h80));
    loadConst(4'd2, 16'h00C7);
    emitWord(rWord(LOAD, 4'd3, 4'd0, 4'd2));
    storeValue(4'd3, ramFill(8'hC7));
    loadConst(4'd6, 16'h0055);
    loadConst(4'd7, 16'hA5C3);
    emitWord(rWord(STR, 4'd7, 4'd0, 4'd6));  // write then read back
    expQ.push_back({16'h0055, 16'hA5C3});
    emitWord(rWord(LOAD, 4'd8, 4'd0, 4'd6));
    storeValue(4'd8, 16'hA5C3);
    endProgram();
    runProgram("load/store");
    if (memHolds != 7)
      reportValue("two-cycle memory fetches", memHolds, 7);
  endtask

  task automatic jumpTest();
    logic [15:0] link;
    int          skipAddr;
    beginProgram();
    loadConst(4'd8, 16'hDEAD);
    loadConst(4'd9, 16'h3333);
    loadConst(4'd10, 16'h0030);
    link = pcIdx + 1;
    emitWord(rWord(JAL, 4'd0, 4'd0, 4'd10));
    expQ.push_back({STORE_BASE, 16'h7777});  // subroutine store comes first
    storeValue(4'd15, link);
    loadConst(4'd11, 16'h0038);
    emitWord(rWord(J, 4'd0, 4'd0, 4'd11));
    skipAddr = pcIdx;
    storeRaw(4'd8);  // jumped over
    pcIdx = 'h30;    // subroutine
    loadConst(4'd12, 16'h7777);
    storeRaw(4'd12);
    emitWord(rWord(JRA, 4'd0, 4'd0, 4'd0));
    pcIdx = 'h38;    // J target
    storeValue(4'd9, 16'h3333);
    endProgram();
    runProgram("jump");
    if (!visited['h38])
    begin
      valueErrors++;
      $display("FAIL %0t: J target 0038 never reached on instrAddr", $time);
    end
    if (visited[skipAddr])
    begin
      valueErrors++;
      $display("FAIL %0t: instruction after J at %h was fetched", $time, skipAddr);
    end
  endtask

  task automatic randomTest();
    int          n;
    logic [15:0] a;
    logic [15:0] b;
    logic [3:0]  code;
    beginProgram();
    for (n = 0; n < 20; n++)
    begin
      a = nextRand();
      b = nextRand();
      if (n % 4 == 2)
        b = a;  // some equal pairs
      loadConst(4'd1, a);
      loadConst(4'd2, b);
      case (n % 3)
        0: aluCase(ADD, a + b);
        1: aluCase(XOR, a ^ b);
        default:
        begin
          code = pickCode(nextRand());
          emitWord(rWord(RTYPE, 4'd1, CMP, 4'd2));
          scondCheck(code, a, b);
        end
      endcase
    end
    endProgram();
    runProgram("random");
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    reset = 1'b1;
    lcgState = 32'hedc2_5ff8;
    valueErrors = 0;
    protocolErrors = 0;
    cycleCount = 0;
    pcIdx = 0;
    haltAddr = 16'h0000;
    for (int i = 0; i < 1024; i++)
      rom[i] = 16'h0000;
    for (int i = 0; i < 256; i++)
      ram[i] = ramFill(i[7:0]);
    aluTest();
    shiftTest();
    condTest();
    memTest();
    jumpTest();
    randomTest();
    $display("errors: %0d value mismatches, %0d protocol errors", valueErrors,
             protocolErrors);
    if (valueErrors == 0 && protocolErrors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
cpuPkg.sv
logicController.sv
aluUnit.sv
shiftUnit.sv
registerFile.sv
cpuCore.sv
tbCpu.sv
